//--- logic/analyzer_pkg.sv
package analyzer_pkg;

	// sweep generator frequency word
	localparam int FREQ_W = 18;
	// rate select feeds a left shift of the sweep step
	localparam int SWEEP_RATE_W = 3;

	// phase accumulator, tracking correction and nco step share this width
	localparam int PHASE_W = 12;
	// table address is the top of the phase
	localparam int ADDR_W = 10;
	localparam int TABLE_DEPTH = 1024;

	// signed samples out of the nco and the filter
	localparam int SAMPLE_W = 12;
	// peak value stored in the sine table
	localparam int TABLE_AMPLITUDE = 2047;
	// 90 degrees in the 12 bit phase
	localparam logic [PHASE_W-1:0] QUARTER_TURN = 12'd1024;

	// full width of quad_sample * filtered
	localparam int PROD_W = 2 * SAMPLE_W;
	// tracking accumulator, top PHASE_W bits steer the nco
	localparam int ACC_W = 36;

	// offset-binary converter code
	localparam int DAC_W = 14;

	// window length is 1 << win_sel
	localparam int WIN_SEL_W = 2;

	// used when the sine table is filled at elaboration
	localparam real TWO_PI = 6.283185307179586;

endpackage

//--- logic/sweep_gen.sv
module sweep_gen #(
	parameter int DWELL_CYCLES = 64
) (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic                                   sweep_enable,
	input  logic [analyzer_pkg::SWEEP_RATE_W-1:0]  sweep_rate,
	input  logic [analyzer_pkg::FREQ_W-1:0]        fixed_freq,
	output logic [analyzer_pkg::FREQ_W-1:0]        freq_word,
	output logic                                   dwell_pulse
);

	// counter must hold DWELL_CYCLES-1, at least one bit
	localparam int CNT_W = (DWELL_CYCLES > 2) ? $clog2(DWELL_CYCLES) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DWELL_CYCLES - 1);

	logic [CNT_W-1:0]                dwell_cnt;
	logic                            dwell_wrap;
	logic [analyzer_pkg::FREQ_W-1:0] freq_step;

	// last cycle of the dwell period
	assign dwell_wrap = (dwell_cnt == CNT_LAST);

	// step size grows by powers of two with the rate select
	assign freq_step = analyzer_pkg::FREQ_W'(1) << sweep_rate;

	// dwell counter
	// only runs in sweep mode, restarts from zero on entry
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dwell_cnt <= '0;
		end else if (!sweep_enable) begin
			dwell_cnt <= '0;
		end else if (dwell_wrap) begin
			dwell_cnt <= '0;
		end else begin
			dwell_cnt <= dwell_cnt + 1'b1;
		end
	end

	// frequency register
	// fixed mode follows fixed_freq with one cycle of delay
	// sweep mode steps once per dwell period, wrapping at the word width
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			freq_word <= '0;
		end else if (!sweep_enable) begin
			freq_word <= fixed_freq;
		end else if (dwell_wrap) begin
			freq_word <= freq_word + freq_step;
		end
	end

	// pulse lines up with the cycle the new word appears
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dwell_pulse <= 1'b0;
		end else begin
			dwell_pulse <= sweep_enable && dwell_wrap;
		end
	end

endmodule

//--- logic/nco.sv
module nco (
	input  logic                                     clk,
	input  logic                                     rst_n,
	input  logic [analyzer_pkg::PHASE_W-1:0]         freq_step,
	input  logic [analyzer_pkg::PHASE_W-1:0]         correction,
	output logic signed [analyzer_pkg::SAMPLE_W-1:0] ref_sample,
	output logic signed [analyzer_pkg::SAMPLE_W-1:0] quad_sample
);

	localparam int PHASE_W = analyzer_pkg::PHASE_W;
	localparam int ADDR_W = analyzer_pkg::ADDR_W;

	// one sine table, read through two ports
	logic signed [analyzer_pkg::SAMPLE_W-1:0] sine_table [analyzer_pkg::TABLE_DEPTH];

	logic [PHASE_W-1:0] phase;
	logic [PHASE_W-1:0] quad_phase;
	logic [ADDR_W-1:0]  ref_addr;
	logic [ADDR_W-1:0]  quad_addr;

	// fill the table once at elaboration
	// rounding is half away from zero, $rtoi truncates toward zero
	initial begin
		real angle;
		real value;
		int  entry;
		for (int k = 0; k < analyzer_pkg::TABLE_DEPTH; k++) begin
			angle = analyzer_pkg::TWO_PI * real'(k) / real'(analyzer_pkg::TABLE_DEPTH);
			value = real'(analyzer_pkg::TABLE_AMPLITUDE) * $sin(angle);
			if (value >= 0.0) begin
				entry = $rtoi(value + 0.5);
			end else begin
				entry = -$rtoi(0.5 - value);
			end
			sine_table[k] = analyzer_pkg::SAMPLE_W'(entry);
		end
	end

	// phase accumulator, wraps modulo 2**PHASE_W
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			phase <= '0;
		end else begin
			phase <= phase + freq_step;
		end
	end

	// cosine port rides on the loop correction plus a quarter turn
	assign quad_phase = phase + correction + analyzer_pkg::QUARTER_TURN;

	// table index is the top of each phase
	assign ref_addr  = phase[PHASE_W-1 -: ADDR_W];
	assign quad_addr = quad_phase[PHASE_W-1 -: ADDR_W];

	// registered reads
	// samples trail the phase register by one cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ref_sample  <= '0;
			quad_sample <= '0;
		end else begin
			ref_sample  <= sine_table[ref_addr];
			quad_sample <= sine_table[quad_addr];
		end
	end

endmodule

//--- logic/window_filter.sv
module window_filter #(
	parameter int MAX_WIN_LOG2 = 3
) (
	input  logic                                     clk,
	input  logic                                     rst_n,
	input  logic signed [analyzer_pkg::SAMPLE_W-1:0] sample_in,
	input  logic [analyzer_pkg::WIN_SEL_W-1:0]       win_sel,
	output logic signed [analyzer_pkg::SAMPLE_W-1:0] filtered
);

	localparam int SAMPLE_W = analyzer_pkg::SAMPLE_W;
	// longest window, the current sample plus HIST_LEN older ones
	localparam int MAX_LEN = 1 << MAX_WIN_LOG2;
	localparam int HIST_LEN = MAX_LEN - 1;
	// headroom for MAX_LEN samples added together
	localparam int SUM_W = SAMPLE_W + MAX_WIN_LOG2;

	logic signed [SAMPLE_W-1:0]              history [HIST_LEN];
	logic [analyzer_pkg::WIN_SEL_W-1:0]      eff_sel;
	logic signed [SUM_W-1:0]                 win_sum;
	logic signed [SUM_W-1:0]                 win_avg;

	// selects above the history depth fall back to the longest window
	always_comb begin
		if (int'(win_sel) > MAX_WIN_LOG2) begin
			eff_sel = analyzer_pkg::WIN_SEL_W'(MAX_WIN_LOG2);
		end else begin
			eff_sel = win_sel;
		end
	end

	// history[0] holds the previous input, history[HIST_LEN-1] the oldest
	// cleared on reset so the first outputs see zero history
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < HIST_LEN; i++) begin
				history[i] <= '0;
			end
		end else begin
			history[0] <= sample_in;
			for (int i = 1; i < HIST_LEN; i++) begin
				history[i] <= history[i-1];
			end
		end
	end

	// sum of the current sample and the newest (1 << eff_sel) - 1 history entries
	always_comb begin
		win_sum = SUM_W'(sample_in);
		for (int i = 0; i < HIST_LEN; i++) begin
			if (i < (1 << eff_sel) - 1) begin
				win_sum = win_sum + SUM_W'(history[i]);
			end
		end
	end

	// divide by the window length, keeps unity gain at dc
	assign win_avg = win_sum >>> eff_sel;

	// one cycle of latency
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			filtered <= '0;
		end else begin
			filtered <= SAMPLE_W'(win_avg);
		end
	end

endmodule

//--- logic/output_stage.sv
module output_stage (
	input  logic                                     clk,
	input  logic                                     rst_n,
	input  logic signed [analyzer_pkg::SAMPLE_W-1:0] quad_sample,
	input  logic signed [analyzer_pkg::SAMPLE_W-1:0] filtered,
	input  logic signed [analyzer_pkg::SAMPLE_W-1:0] ref_sample,
	input  logic                                     track_enable,
	input  logic                                     monitor_select,
	output logic [analyzer_pkg::PHASE_W-1:0]         correction,
	output logic [analyzer_pkg::DAC_W-1:0]           dac_code
);

	localparam int ACC_W = analyzer_pkg::ACC_W;
	localparam int DAC_W = analyzer_pkg::DAC_W;
	localparam int SAMPLE_W = analyzer_pkg::SAMPLE_W;
	// bits appended below the sample to reach the converter width
	localparam int PAD_W = DAC_W - SAMPLE_W;

	logic signed [analyzer_pkg::PROD_W-1:0] phase_err;
	logic signed [ACC_W-1:0]                phase_err_ext;
	logic signed [ACC_W-1:0]                track_acc;
	logic signed [SAMPLE_W-1:0]             mon_sample;
	// two's complement code, converted to offset binary on the way out
	logic signed [DAC_W-1:0]                mon_word;

	// phase detector
	// quadrature reference times the system under test output
	assign phase_err = quad_sample * filtered;

	// sign extend up to the accumulator width
	assign phase_err_ext = ACC_W'(phase_err);

	// loop integrator
	// held at zero while tracking is off so the nco runs open loop
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			track_acc <= '0;
		end else if (track_enable) begin
			track_acc <= track_acc + phase_err_ext;
		end else begin
			track_acc <= '0;
		end
	end

	// top of the integrator steers the cosine table port
	assign correction = track_acc[ACC_W-1 -: analyzer_pkg::PHASE_W];

	// monitor source, filter output or raw reference
	assign mon_sample = monitor_select ? filtered : ref_sample;

	// output code register
	// sample is left aligned to the converter width
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mon_word <= '0;
		end else begin
			mon_word <= {mon_sample, {PAD_W{1'b0}}};
		end
	end

	// flipping the sign bit turns two's complement into offset binary,
	// so a cleared register reads as mid scale
	assign dac_code = {~mon_word[DAC_W-1], mon_word[DAC_W-2:0]};

endmodule

//--- logic/analyzer_top.sv
module analyzer_top #(
	parameter int DWELL_CYCLES = 64,
	parameter int MAX_WIN_LOG2 = 3
) (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  sweep_enable,
	input  logic [analyzer_pkg::SWEEP_RATE_W-1:0] sweep_rate,
	input  logic [analyzer_pkg::FREQ_W-1:0]       fixed_freq,
	input  logic [analyzer_pkg::WIN_SEL_W-1:0]    win_sel,
	input  logic                                  track_enable,
	input  logic                                  monitor_select,
	output logic [analyzer_pkg::FREQ_W-1:0]       freq_word,
	output logic                                  dwell_pulse,
	output logic [analyzer_pkg::PHASE_W-1:0]      correction,
	output logic [analyzer_pkg::DAC_W-1:0]        dac_code
);

	logic [analyzer_pkg::PHASE_W-1:0]         nco_step;
	logic signed [analyzer_pkg::SAMPLE_W-1:0] ref_sample;
	logic signed [analyzer_pkg::SAMPLE_W-1:0] quad_sample;
	logic signed [analyzer_pkg::SAMPLE_W-1:0] filtered;

	// stimulus side
	sweep_gen #(
		.DWELL_CYCLES (DWELL_CYCLES)
	) u_sweep_gen (
		.clk          (clk),
		.rst_n        (rst_n),
		.sweep_enable (sweep_enable),
		.sweep_rate   (sweep_rate),
		.fixed_freq   (fixed_freq),
		.freq_word    (freq_word),
		.dwell_pulse  (dwell_pulse)
	);

	// nco only sees the coarse part of the sweep word
	assign nco_step = freq_word[analyzer_pkg::FREQ_W-1 -: analyzer_pkg::PHASE_W];

	nco u_nco (
		.clk         (clk),
		.rst_n       (rst_n),
		.freq_step   (nco_step),
		.correction  (correction),
		.ref_sample  (ref_sample),
		.quad_sample (quad_sample)
	);

	// system under test
	window_filter #(
		.MAX_WIN_LOG2 (MAX_WIN_LOG2)
	) u_window_filter (
		.clk       (clk),
		.rst_n     (rst_n),
		.sample_in (ref_sample),
		.win_sel   (win_sel),
		.filtered  (filtered)
	);

	// tracking loop closes back into the nco through correction
	output_stage u_output_stage (
		.clk            (clk),
		.rst_n          (rst_n),
		.quad_sample    (quad_sample),
		.filtered       (filtered),
		.ref_sample     (ref_sample),
		.track_enable   (track_enable),
		.monitor_select (monitor_select),
		.correction     (correction),
		.dac_code       (dac_code)
	);

endmodule

//--- sim/analyzer_properties.sv
module analyzer_properties (
	input logic                              clk,
	input logic                              rst_n,
	input logic                              sweep_enable,
	input logic                              track_enable,
	input logic                              dwell_pulse,
	input logic [analyzer_pkg::PHASE_W-1:0]  correction,
	input logic [analyzer_pkg::DAC_W-1:0]    dac_code
);
	timeunit 1ns;
	timeprecision 100ps;

	// one pulse per wrap, never two in a row
	a_pulse_single: assert property (@(posedge clk) disable iff (!rst_n)
		dwell_pulse |=> !dwell_pulse)
		else $error("dwell_pulse high on two consecutive cycles");

	// no pulse out of fixed mode
	a_pulse_needs_sweep: assert property (@(posedge clk) disable iff (!rst_n)
		!sweep_enable |=> !dwell_pulse)
		else $error("dwell_pulse after a cycle with sweep_enable low");

	// integrator cleared once tracking is off
	a_corr_cleared: assert property (@(posedge clk) disable iff (!rst_n)
		(!track_enable && $past(!track_enable)) |=> (correction == '0))
		else $error("correction nonzero with tracking off");

	// mid scale right after reset
	a_dac_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> (dac_code == analyzer_pkg::DAC_W'(8192)))
		else $error("dac_code not at mid scale after reset");

endmodule

bind analyzer_top analyzer_properties u_properties (
	.clk          (clk),
	.rst_n        (rst_n),
	.sweep_enable (sweep_enable),
	.track_enable (track_enable),
	.dwell_pulse  (dwell_pulse),
	.correction   (correction),
	.dac_code     (dac_code)
);

//--- sim/analyzer_tb.sv
module analyzer_tb;
	timeunit 1ns;
	timeprecision 100ps;

	// same values as the analyzer_top defaults
	localparam int DWELL_CYCLES = 64;
	localparam int MAX_WIN_LOG2 = 3;
	localparam int HIST_LEN = (1 << MAX_WIN_LOG2) - 1;
	localparam int TONE_COUNT = 4;
	localparam int TONE_CYCLES = 40;
	localparam int SWEEP_DWELLS = 3;
	localparam int TRACK_CYCLES = 200;
	localparam int IDLE_CYCLES = 16;
	// cycles of all tests together with a small margin per segment
	localparam int TOTAL_CYCLES = 8 + TONE_COUNT * (TONE_CYCLES + 2) + 4 * (TONE_CYCLES + 3)
		+ 2 * (DWELL_CYCLES * SWEEP_DWELLS + 4) + TRACK_CYCLES + IDLE_CYCLES + 4;

	logic                                  clk = 1'b0;
	logic                                  rst_n;
	logic                                  sweep_enable;
	logic [analyzer_pkg::SWEEP_RATE_W-1:0] sweep_rate;
	logic [analyzer_pkg::FREQ_W-1:0]       fixed_freq;
	logic [analyzer_pkg::WIN_SEL_W-1:0]    win_sel;
	logic                                  track_enable;
	logic                                  monitor_select;
	logic [analyzer_pkg::FREQ_W-1:0]       freq_word;
	logic                                  dwell_pulse;
	logic [analyzer_pkg::PHASE_W-1:0]      correction;
	logic [analyzer_pkg::DAC_W-1:0]        dac_code;

	// reference model state with one variable per DUT register
	logic signed [analyzer_pkg::SAMPLE_W-1:0] sine_ref [analyzer_pkg::TABLE_DEPTH];
	int                                       m_cnt;
	logic [analyzer_pkg::FREQ_W-1:0]          m_freq;
	logic                                     m_pulse;
	logic [analyzer_pkg::PHASE_W-1:0]         m_phase;
	logic signed [analyzer_pkg::SAMPLE_W-1:0] m_ref;
	logic signed [analyzer_pkg::SAMPLE_W-1:0] m_quad;
	logic signed [analyzer_pkg::SAMPLE_W-1:0] m_hist [HIST_LEN];
	logic signed [analyzer_pkg::SAMPLE_W-1:0] m_filt;
	logic signed [analyzer_pkg::ACC_W-1:0]    m_acc;
	logic signed [analyzer_pkg::SAMPLE_W-1:0] m_mon;

	logic [31:0]                     rng_state = 32'd32702;
	logic [analyzer_pkg::FREQ_W-1:0] prev_freq;
	string                           cur_test;
	int                              pulse_count;
	int                              err_count = 0;
	int                              test_errs = 0;
	int                              tests_run = 0;
	int                              tests_failed = 0;

	analyzer_top UUT (
		.clk            (clk),
		.rst_n          (rst_n),
		.sweep_enable   (sweep_enable),
		.sweep_rate     (sweep_rate),
		.fixed_freq     (fixed_freq),
		.win_sel        (win_sel),
		.track_enable   (track_enable),
		.monitor_select (monitor_select),
		.freq_word      (freq_word),
		.dwell_pulse    (dwell_pulse),
		.correction     (correction),
		.dac_code       (dac_code)
	);

	// 4 ns period
	always #2 clk = ~clk;

	// lcg with the numerical recipes constants
	function automatic logic [31:0] next_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// nearest integer to the scaled sine with halves rounded away from zero
	function automatic void build_table();
		real x;
		for (int k = 0; k < analyzer_pkg::TABLE_DEPTH; k++) begin
			x = 2047.0 * $sin(2.0 * $acos(-1.0) * k / analyzer_pkg::TABLE_DEPTH);
			if (x >= 0.0) begin
				sine_ref[k] = analyzer_pkg::SAMPLE_W'($rtoi($floor(x + 0.5)));
			end else begin
				sine_ref[k] = analyzer_pkg::SAMPLE_W'(-$rtoi($floor(0.5 - x)));
			end
		end
	endfunction

	// one clock of every register
	// consumers are updated before their producers so each reads the old value
	function automatic void step_model();
		logic [analyzer_pkg::PHASE_W-1:0]       quad_phase;
		logic signed [analyzer_pkg::PROD_W-1:0] product;
		int                                     sum;
		int                                     sel;
		if (!rst_n) begin
			m_cnt = 0;
			m_freq = '0;
			m_pulse = 1'b0;
			m_phase = '0;
			m_ref = '0;
			m_quad = '0;
			m_filt = '0;
			m_acc = '0;
			m_mon = '0;
			foreach (m_hist[i]) begin
				m_hist[i] = '0;
			end
		end else begin
			// quadrature phase uses the correction of this cycle
			quad_phase = m_phase + m_acc[35:24] + 12'd1024;
			// output stage
			product = m_quad * m_filt;
			m_mon = monitor_select ? m_filt : m_ref;
			if (track_enable) begin
				m_acc = m_acc + product;
			end else begin
				m_acc = '0;
			end
			// moving average over 1 << sel samples
			sel = (int'(win_sel) > MAX_WIN_LOG2) ? MAX_WIN_LOG2 : int'(win_sel);
			sum = int'(m_ref);
			for (int i = 0; i < (1 << sel) - 1; i++) begin
				sum += int'(m_hist[i]);
			end
			m_filt = analyzer_pkg::SAMPLE_W'(sum >>> sel);
			for (int i = HIST_LEN - 1; i > 0; i--) begin
				m_hist[i] = m_hist[i-1];
			end
			m_hist[0] = m_ref;
			// table reads before the phase step from the top 12 bits of the word
			m_ref = sine_ref[m_phase[11:2]];
			m_quad = sine_ref[quad_phase[11:2]];
			m_phase = m_phase + m_freq[17:6];
			// sweep generator
			if (!sweep_enable) begin
				m_freq = fixed_freq;
				m_cnt = 0;
				m_pulse = 1'b0;
			end else if (m_cnt == DWELL_CYCLES - 1) begin
				m_freq = m_freq + (analyzer_pkg::FREQ_W'(1) << sweep_rate);
				m_cnt = 0;
				m_pulse = 1'b1;
			end else begin
				m_cnt++;
				m_pulse = 1'b0;
			end
		end
	endfunction

	function automatic void check_equal(string what, logic [35:0] expected, logic [35:0] actual);
		assert (actual === expected) else begin
			$display("MISMATCH %s %s expected %0d actual %0d", cur_test, what, expected, actual);
			err_count++;
			test_errs++;
		end
	endfunction

	task automatic start_test(string name);
		cur_test = name;
		test_errs = 0;
	endtask

	task automatic finish_test();
		tests_run++;
		if (test_errs != 0) begin
			tests_failed++;
		end
		$display("test %-12s %s, %0d errors", cur_test, (test_errs == 0) ? "ok" : "failed",
			test_errs);
	endtask

	// model advances on the same edge as the DUT
	always @(posedge clk) begin
		step_model();
	end

	// compare half a period later when outputs are settled
	always @(negedge clk) begin
		logic [analyzer_pkg::FREQ_W-1:0] stepped;
		check_equal("dac_code", int'(m_mon) * 4 + 8192, dac_code);
		check_equal("correction", m_acc[35:24], correction);
		check_equal("freq_word", m_freq, freq_word);
		check_equal("dwell_pulse", m_pulse, dwell_pulse);
		// each pulse must carry exactly one rate-scaled step
		if (dwell_pulse === 1'b1) begin
			pulse_count++;
			stepped = prev_freq + (analyzer_pkg::FREQ_W'(1) << sweep_rate);
			check_equal("freq step", stepped, freq_word);
		end
		prev_freq = m_freq;
	end

	initial begin
		logic [31:0] r;
		rst_n = 1'b0;
		sweep_enable = 1'b0;
		sweep_rate = '0;
		fixed_freq = '0;
		win_sel = '0;
		track_enable = 1'b0;
		monitor_select = 1'b0;
		build_table();

		// reset values while rst_n is low
		start_test("reset");
		repeat (4) @(posedge clk);
		@(negedge clk);
		check_equal("reset dac_code", 8192, dac_code);
		check_equal("reset correction", 0, correction);
		check_equal("reset freq_word", 0, freq_word);
		check_equal("reset dwell_pulse", 0, dwell_pulse);
		@(posedge clk);
		rst_n <= 1'b1;
		finish_test();

		// raw reference on the output
		start_test("fixed_tone");
		for (int t = 0; t < TONE_COUNT; t++) begin
			@(posedge clk);
			r = next_random();
			fixed_freq <= r[31:14];
			r = next_random();
			win_sel <= r[31:30];
			repeat (TONE_CYCLES - 1) @(posedge clk);
		end
		finish_test();

		// short reset per window so the zero history is seen
		start_test("window");
		for (int s = 0; s < 4; s++) begin
			@(posedge clk);
			r = next_random();
			rst_n <= 1'b0;
			monitor_select <= 1'b1;
			win_sel <= 2'(s);
			fixed_freq <= r[31:14];
			@(posedge clk);
			rst_n <= 1'b1;
			repeat (TONE_CYCLES) @(posedge clk);
		end
		finish_test();

		// sweep at two rates with the counter restarted in between
		start_test("sweep");
		for (int k = 0; k < 2; k++) begin
			@(posedge clk);
			sweep_enable <= 1'b0;
			sweep_rate <= (k == 0) ? 3'd0 : 3'd5;
			@(posedge clk);
			sweep_enable <= 1'b1;
			pulse_count = 0;
			repeat (DWELL_CYCLES * SWEEP_DWELLS) @(posedge clk);
			@(negedge clk);
			#1;
			check_equal("dwell pulse count", SWEEP_DWELLS, pulse_count);
		end
		@(posedge clk);
		sweep_enable <= 1'b0;
		finish_test();

		// closed loop followed by release
		start_test("tracking");
		@(posedge clk);
		r = next_random();
		fixed_freq <= r[31:14];
		r = next_random();
		win_sel <= r[31:30];
		monitor_select <= 1'b1;
		track_enable <= 1'b1;
		repeat (TRACK_CYCLES) @(posedge clk);
		track_enable <= 1'b0;
		repeat (IDLE_CYCLES) @(posedge clk);
		@(negedge clk);
		check_equal("released correction", 0, correction);
		finish_test();

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
		if (err_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	// watchdog at one and a half times the total test length
	initial begin
		#(1.5 * TOTAL_CYCLES * 4.0);
		$display("timeout: tests did not complete within %0d cycles", TOTAL_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- list.f
logic/analyzer_pkg.sv
logic/sweep_gen.sv
logic/nco.sv
logic/window_filter.sv
logic/output_stage.sv
logic/analyzer_top.sv
sim/analyzer_properties.sv
sim/analyzer_tb.sv
